// File: Bender.yml
package:
  name: uart

sources:
  - files:
      - hdl/uart_pkg.sv
      - hdl/reg_bus_if.sv
      - hdl/register_file.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/line_status.sv
      - hdl/uart_top.sv
  - target: simulation
    files:
      - dv/uart_checker.sv
      - dv/uart_tb.sv

// File: dv/uart_checker.sv
`timescale 1ns/10ps

module uart_checker (
    input logic                        clk,
    input logic                        reset_n,
    input logic                        en_i,
    input logic                        wr_rd_i,
    input logic [uart_pkg::ADDR_W-1:0] addr_i,
    input logic                        err_i,
    input logic                        start_i,
    input logic [3:0]                  iir_i,
    input logic [3:0]                  lsr_i,
    input logic [2:0]                  ier_i,
    input logic                        irq_i,
    input logic                        tx_idle_i,
    input logic                        tx_i
);

    logic       writable;
    logic       known;
    logic       bad_access;
    logic [2:0] cause;   // In IER bit order
    int         fail_count = 0;

    assign writable = addr_i inside {uart_pkg::ADDR_TDR, uart_pkg::ADDR_LCR, uart_pkg::ADDR_OCR,
                                     uart_pkg::ADDR_FCR, uart_pkg::ADDR_IER, uart_pkg::ADDR_HCR};
    assign known    = writable ||
                      (addr_i inside {uart_pkg::ADDR_RDR, uart_pkg::ADDR_LSR, uart_pkg::ADDR_IIR});
    assign bad_access = en_i && (wr_rd_i ? !writable : !known);

    assign cause[uart_pkg::IER_RXDATA]  = lsr_i[uart_pkg::LSR_DR];
    assign cause[uart_pkg::IER_TXEMPTY] = lsr_i[uart_pkg::LSR_TEMT];
    assign cause[uart_pkg::IER_LINE]    = lsr_i[uart_pkg::LSR_OE] || lsr_i[uart_pkg::LSR_FE];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus and control timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    addr_err_a: assert property (@(posedge clk) disable iff (!reset_n)
        bad_access |=> err_i)
        else begin
            $error("addr_err_o did not follow an invalid access");
            fail_count++;
        end

    start_pulse_a: assert property (@(posedge clk) disable iff (!reset_n)
        start_i |=> !start_i)
        else begin
            $error("OCR start bit held for two cycles");
            fail_count++;
        end

    irq_cause_a: assert property (@(posedge clk) disable iff (!reset_n)
        (irq_i == |(cause & ier_i)) && (irq_i == (iir_i != uart_pkg::IIR_NONE)))
        else begin
            $error("irq_o does not match the enabled interrupt causes");
            fail_count++;
        end

    tx_idle_a: assert property (@(posedge clk) disable iff (!reset_n)
        tx_idle_i |-> tx_i)
        else begin
            $error("tx_o low while transmitter idle");
            fail_count++;
        end

endmodule

bind uart_top uart_checker u_checker (
    .clk, .reset_n, .en_i, .wr_rd_i, .addr_i,
    .err_i(addr_err_o), .start_i(u_regs.ocr_o[uart_pkg::OCR_START]),
    .iir_i(u_status.iir_o[3:0]), .lsr_i(lsr[3:0]), .ier_i(ier[2:0]), .irq_i(irq_o),
    .tx_idle_i(u_tx.idle_o), .tx_i(tx_o)
);

// File: dv/uart_tb.sv
`timescale 1ns/10ps

module uart_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int BIT_CYCLES   = 16;   // Divisor 15 plus one
    localparam int FRAMES       = 7;
    localparam int POLL_LIMIT   = 20 * BIT_CYCLES;
    // All frames at the slowest rate plus register traffic, doubled
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + FRAMES * 12 * BIT_CYCLES + 1000);

    logic                        clk;
    logic                        reset_n;
    logic                        en;
    logic                        wr_rd;
    logic [uart_pkg::ADDR_W-1:0] addr;
    uart_pkg::reg_data_t         pwdata;
    logic [uart_pkg::STRB_W-1:0] strb;
    uart_pkg::reg_data_t         prdata;
    logic                        addr_err;
    logic                        rx;
    logic                        tx;
    logic                        irq;

    uart_pkg::reg_data_t         model [9];   // Indexed by word address
    uart_pkg::reg_data_t         val;
    uart_pkg::reg_data_t         wdata;
    logic [uart_pkg::ADDR_W-1:0] a;
    logic [7:0]                  b;
    int                          div;
    string                       test_name;

    uart_top #(.DIV_W(16)) UUT (
        .clk, .reset_n, .en_i(en), .wr_rd_i(wr_rd), .addr_i(addr),
        .pwdata_i(pwdata), .byte_strobe_i(strb), .prdata_o(prdata),
        .addr_err_o(addr_err), .rx_i(rx), .tx_o(tx), .irq_o(irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_run("Timeout: the tests did not finish in the expected time");
    end

    always @(negedge clk) begin
        if (UUT.u_checker.fail_count != 0)
            stop_run("A bound assertion in uart_checker failed");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string what, input uart_pkg::reg_data_t exp_val,
                              input uart_pkg::reg_data_t act_val);
        if (act_val !== exp_val)
            stop_run($sformatf("ERROR %s %s: expected %h, actual %h",
                               test_name, what, exp_val, act_val));
    endtask

    task automatic check_bit(input string what, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
            stop_run($sformatf("ERROR %s %s: expected %b, actual %b",
                               test_name, what, exp_val, act_val));
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp_val,
                              input logic [7:0] act_val);
        if (act_val !== exp_val)
            stop_run($sformatf("ERROR %s %s: expected %h, actual %h",
                               test_name, what, exp_val, act_val));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register model and bus access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic uart_pkg::reg_data_t strobe_merge(input uart_pkg::reg_data_t old_w,
            input uart_pkg::reg_data_t new_w, input logic [3:0] lanes);
        uart_pkg::reg_data_t mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic valid_addr(input logic [uart_pkg::ADDR_W-1:0] reg_addr);
        return reg_addr inside {uart_pkg::ADDR_TDR, uart_pkg::ADDR_RDR, uart_pkg::ADDR_LCR,
                                uart_pkg::ADDR_OCR, uart_pkg::ADDR_LSR, uart_pkg::ADDR_FCR,
                                uart_pkg::ADDR_IER, uart_pkg::ADDR_IIR, uart_pkg::ADDR_HCR};
    endfunction

    task automatic bus_access(input logic write, input logic [uart_pkg::ADDR_W-1:0] reg_addr,
                              input uart_pkg::reg_data_t data, input logic [3:0] lanes);
        @(negedge clk);
        en     = 1'b1;
        wr_rd  = write;
        addr   = reg_addr;
        pwdata = data;
        strb   = lanes;
        @(negedge clk);
        en = 1'b0;   // Response now stable
    endtask

    task automatic reg_write(input logic [uart_pkg::ADDR_W-1:0] reg_addr,
                             input uart_pkg::reg_data_t data, input logic [3:0] lanes,
                             input logic exp_err);
        int idx;
        idx = reg_addr[5:2];
        bus_access(1'b1, reg_addr, data, lanes);
        check_bit("write error flag", exp_err, addr_err);
        if (!exp_err) begin
            model[idx] = strobe_merge(model[idx], data, lanes);
            if (reg_addr == uart_pkg::ADDR_OCR)
                model[idx][uart_pkg::OCR_START] = 1'b0;   // Self-clearing
        end
    endtask

    task automatic reg_read(input logic [uart_pkg::ADDR_W-1:0] reg_addr, input logic exp_err,
                            output uart_pkg::reg_data_t data);
        bus_access(1'b0, reg_addr, '0, 4'h0);
        check_bit("read error flag", exp_err, addr_err);
        data = prdata;
    endtask

    task automatic wait_lsr(input int bit_pos, output uart_pkg::reg_data_t lsr_val);
        int polls;
        polls = 0;
        reg_read(uart_pkg::ADDR_LSR, 1'b0, lsr_val);
        while (!lsr_val[bit_pos]) begin
            polls++;
            if (polls > POLL_LIMIT)
                stop_run($sformatf("LSR bit %0d never came up in test %s", bit_pos, test_name));
            reg_read(uart_pkg::ADDR_LSR, 1'b0, lsr_val);
        end
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        while (irq !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > POLL_LIMIT)
                stop_run($sformatf("irq_o never went high in test %s", test_name));
        end
    endtask

    task automatic send_byte(input logic [7:0] data);
        reg_write(uart_pkg::ADDR_TDR, {24'h0, data}, 4'b0001, 1'b0);
        reg_write(uart_pkg::ADDR_OCR, 32'h1 << uart_pkg::OCR_START, 4'b0001, 1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial model, 8N1 frame LSB first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_tx_frame(input logic [7:0] data, input int bit_div);
        logic [9:0] got;
        int         waited;
        waited = 0;
        while (tx !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > POLL_LIMIT)
                stop_run("tx_o never dropped for the start bit");
        end
        repeat ((bit_div + 1) / 2) @(negedge clk);   // To mid start bit
        got[0] = tx;
        for (int k = 1; k < 10; k++) begin
            repeat (bit_div + 1) @(negedge clk);
            got[k] = tx;
        end
        check_bit("start bit", 1'b0, got[0]);
        check_byte("data bits", data, got[8:1]);
        check_bit("stop bit", 1'b1, got[9]);
    endtask

    task automatic drive_rx_frame(input logic [7:0] data, input logic stop, input int bit_div);
        logic [9:0] frame;
        frame = {stop, data, 1'b0};
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            rx = frame[k];
            repeat (bit_div) @(negedge clk);
        end
        @(negedge clk);
        rx = 1'b1;
    endtask

    initial begin
        void'($urandom(32'hc42150cc));
        reset_n = 1'b0;
        en = 1'b0;
        wr_rd = 1'b0;
        addr = '0;
        pwdata = '0;
        strb = '0;
        rx = 1'b1;
        foreach (model[i]) model[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        test_name = "reset_values";
        foreach (model[i]) begin
            if (!(i inside {1, 4, 7})) begin
                reg_read(i * 4, 1'b0, val);
                check_word($sformatf("register at %0h", i * 4), 32'h0, val);
            end
        end
        reg_read(uart_pkg::ADDR_LSR, 1'b0, val);
        check_word("LSR", 32'h1 << uart_pkg::LSR_TEMT, val);
        reg_read(uart_pkg::ADDR_IIR, 1'b0, val);
        check_word("IIR", uart_pkg::reg_data_t'(uart_pkg::IIR_NONE), val);
        check_bit("tx_o", 1'b1, tx);
        check_bit("irq_o", 1'b0, irq);

        test_name = "register_writes";
        repeat (20) begin
            case ($urandom % 5)
                0: a = uart_pkg::ADDR_TDR;
                1: a = uart_pkg::ADDR_LCR;
                2: a = uart_pkg::ADDR_FCR;
                3: a = uart_pkg::ADDR_IER;
                default: a = uart_pkg::ADDR_HCR;
            endcase
            wdata = $urandom;
            reg_write(a, wdata, $urandom, 1'b0);
            reg_read(a, 1'b0, val);
            check_word($sformatf("readback of %0h", a), model[a[5:2]], val);
        end

        test_name = "address_errors";
        repeat (8) begin
            a = $urandom;
            while (valid_addr(a)) a = $urandom;
            reg_read(a, 1'b1, val);
            check_word("invalid read data", 32'h0, val);
            reg_write(a, $urandom, 4'hf, 1'b1);
        end
        reg_write(uart_pkg::ADDR_RDR, $urandom, 4'hf, 1'b1);
        reg_write(uart_pkg::ADDR_LSR, $urandom, 4'hf, 1'b1);
        reg_write(uart_pkg::ADDR_IIR, $urandom, 4'hf, 1'b1);

        test_name = "transmit";
        reg_write(uart_pkg::ADDR_FCR, 32'h0, 4'hf, 1'b0);
        reg_write(uart_pkg::ADDR_HCR, 32'h0, 4'hf, 1'b0);
        reg_write(uart_pkg::ADDR_IER, 32'h0, 4'hf, 1'b0);
        repeat (3) begin
            div = 3 + $urandom % 13;
            b = $urandom;
            reg_write(uart_pkg::ADDR_LCR, div, 4'hf, 1'b0);
            send_byte(b);
            check_tx_frame(b, div);
            reg_read(uart_pkg::ADDR_LSR, 1'b0, val);
            check_bit("TEMT during stop bit", 1'b0, val[uart_pkg::LSR_TEMT]);
            reg_read(uart_pkg::ADDR_OCR, 1'b0, val);
            check_bit("OCR start bit", 1'b0, val[uart_pkg::OCR_START]);
            repeat (div + 1) @(negedge clk);   // Past the end of the stop bit
            reg_read(uart_pkg::ADDR_LSR, 1'b0, val);
            check_bit("TEMT", 1'b1, val[uart_pkg::LSR_TEMT]);
        end

        test_name = "loopback_receive";
        reg_write(uart_pkg::ADDR_HCR, 32'h1 << uart_pkg::HCR_LOOP, 4'hf, 1'b0);
        reg_write(uart_pkg::ADDR_FCR, 32'h1 << uart_pkg::FCR_RX_EN, 4'hf, 1'b0);
        reg_write(uart_pkg::ADDR_IER, 32'h1, 4'hf, 1'b0);   // Data ready only
        b = $urandom;
        send_byte(b);
        wait_lsr(uart_pkg::LSR_DR, val);
        check_bit("irq_o on data", 1'b1, irq);
        reg_read(uart_pkg::ADDR_IIR, 1'b0, val);
        check_word("IIR", uart_pkg::reg_data_t'(uart_pkg::IIR_RXDATA), val);
        reg_read(uart_pkg::ADDR_RDR, 1'b0, val);
        check_word("RDR", {24'h0, b}, val);
        reg_read(uart_pkg::ADDR_LSR, 1'b0, val);
        check_bit("DR after RDR read", 1'b0, val[uart_pkg::LSR_DR]);
        check_bit("irq_o after RDR read", 1'b0, irq);
        send_byte($urandom);
        wait_lsr(uart_pkg::LSR_DR, val);
        b = $urandom;
        send_byte(b);   // RDR left unread
        wait_lsr(uart_pkg::LSR_OE, val);
        reg_read(uart_pkg::ADDR_RDR, 1'b0, val);
        check_byte("RDR after overrun", b, val[7:0]);
        reg_read(uart_pkg::ADDR_LSR, 1'b0, val);
        check_bit("OE after LSR read", 1'b0, val[uart_pkg::LSR_OE]);

        test_name = "framing_error";
        reg_write(uart_pkg::ADDR_HCR, 32'h0, 4'hf, 1'b0);
        reg_write(uart_pkg::ADDR_IER, 32'h4, 4'hf, 1'b0);   // Line errors only
        drive_rx_frame($urandom, 1'b0, div);
        wait_irq();
        reg_read(uart_pkg::ADDR_IIR, 1'b0, val);
        check_word("IIR", uart_pkg::reg_data_t'(uart_pkg::IIR_LINE), val);
        check_bit("irq_o on FE", 1'b1, irq);
        reg_read(uart_pkg::ADDR_LSR, 1'b0, val);
        check_word("LSR with FE", (32'h1 << uart_pkg::LSR_FE) | (32'h1 << uart_pkg::LSR_TEMT), val);
        reg_read(uart_pkg::ADDR_LSR, 1'b0, val);
        check_bit("FE after LSR read", 1'b0, val[uart_pkg::LSR_FE]);
        check_bit("irq_o after LSR read", 1'b0, irq);

        if (UUT.u_checker.fail_count != 0) begin
            stop_run("A bound assertion in uart_checker failed");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: hdl/line_status.sv
`timescale 1ns/10ps

module line_status (
    input  logic                clk,
    input  logic                reset_n,
    reg_bus_if.monitor          bus,
    input  logic                rx_done_i,
    input  logic                rx_ferr_i,
    input  logic                tx_idle_i,
    input  uart_pkg::reg_data_t ier_i,
    output uart_pkg::reg_data_t lsr_o,
    output uart_pkg::reg_data_t iir_o,
    output logic                irq_o
);

    logic       rd_rdr;
    logic       rd_lsr;
    logic       dr_q;
    logic       oe_q;
    logic       fe_q;
    logic [3:0] iir_code;

    assign rd_rdr = bus.en && !bus.wr_rd && (bus.addr == uart_pkg::ADDR_RDR);
    assign rd_lsr = bus.en && !bus.wr_rd && (bus.addr == uart_pkg::ADDR_LSR);

    // Sticky bits, a new event beats a clearing read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dr_q <= 1'b0;
            oe_q <= 1'b0;
            fe_q <= 1'b0;
        end else begin
            dr_q <= rx_done_i || (dr_q && !rd_rdr);
            oe_q <= (rx_done_i && dr_q && !rd_rdr) || (oe_q && !rd_lsr);
            fe_q <= rx_ferr_i || (fe_q && !rd_lsr);
        end
    end

    always_comb begin
        lsr_o                     = '0;
        lsr_o[uart_pkg::LSR_DR]   = dr_q;
        lsr_o[uart_pkg::LSR_OE]   = oe_q;
        lsr_o[uart_pkg::LSR_FE]   = fe_q;
        lsr_o[uart_pkg::LSR_TEMT] = tx_idle_i;
    end

    always_comb begin
        if ((oe_q || fe_q) && ier_i[uart_pkg::IER_LINE]) begin
            iir_code = uart_pkg::IIR_LINE;
        end else if (dr_q && ier_i[uart_pkg::IER_RXDATA]) begin
            iir_code = uart_pkg::IIR_RXDATA;
        end else if (tx_idle_i && ier_i[uart_pkg::IER_TXEMPTY]) begin
            iir_code = uart_pkg::IIR_TXEMPTY;
        end else begin
            iir_code = uart_pkg::IIR_NONE;
        end
    end

    assign iir_o = {{(uart_pkg::DATA_W-4){1'b0}}, iir_code};
    assign irq_o = (iir_code != uart_pkg::IIR_NONE);

endmodule

// File: hdl/reg_bus_if.sv
`timescale 1ns/10ps

interface reg_bus_if;

    logic                          en;      // One access per cycle
    logic                          wr_rd;   // 1 = write
    logic [uart_pkg::ADDR_W-1:0]   addr;
    uart_pkg::reg_data_t           wdata;
    logic [uart_pkg::STRB_W-1:0]   strb;
    uart_pkg::reg_data_t           rdata;   // Valid the cycle after en
    logic                          err;

    modport host (
        output en, wr_rd, addr, wdata, strb,
        input  rdata, err
    );

    modport target (
        input  en, wr_rd, addr, wdata, strb,
        output rdata, err
    );

    modport monitor (
        input en, wr_rd, addr, wdata, strb, rdata, err
    );

endinterface

// File: hdl/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                clk,
    input  logic                reset_n,
    reg_bus_if.target           bus,
    input  uart_pkg::reg_data_t rdr_i,
    input  uart_pkg::reg_data_t lsr_i,
    input  uart_pkg::reg_data_t iir_i,
    output uart_pkg::reg_data_t tdr_o,
    output uart_pkg::reg_data_t lcr_o,
    output uart_pkg::reg_data_t ocr_o,
    output uart_pkg::reg_data_t fcr_o,
    output uart_pkg::reg_data_t ier_o,
    output uart_pkg::reg_data_t hcr_o
);

    uart_pkg::reg_data_t rd_word;
    logic                addr_known;
    logic                addr_rw;
    logic                wr_en;
    logic                rd_en;

    // Byte lane merge under strobes
    function automatic uart_pkg::reg_data_t merge_bytes(
        input uart_pkg::reg_data_t        old_word,
        input uart_pkg::reg_data_t        new_word,
        input logic [uart_pkg::STRB_W-1:0] strb
    );
        uart_pkg::reg_data_t result;
        result = old_word;
        for (int i = 0; i < uart_pkg::STRB_W; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    assign wr_en = bus.en && bus.wr_rd;
    assign rd_en = bus.en && !bus.wr_rd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode and read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rd_word    = '0;
        addr_known = 1'b1;
        addr_rw    = 1'b1;
        case (bus.addr)
            uart_pkg::ADDR_TDR: rd_word = tdr_o;
            uart_pkg::ADDR_LCR: rd_word = lcr_o;
            uart_pkg::ADDR_OCR: rd_word = ocr_o;
            uart_pkg::ADDR_FCR: rd_word = fcr_o;
            uart_pkg::ADDR_IER: rd_word = ier_o;
            uart_pkg::ADDR_HCR: rd_word = hcr_o;
            uart_pkg::ADDR_RDR: begin
                rd_word = rdr_i;
                addr_rw = 1'b0;
            end
            uart_pkg::ADDR_LSR: begin
                rd_word = lsr_i;
                addr_rw = 1'b0;
            end
            uart_pkg::ADDR_IIR: begin
                rd_word = iir_i;
                addr_rw = 1'b0;
            end
            default: begin
                addr_known = 1'b0;
                addr_rw    = 1'b0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tdr_o     <= '0;
            lcr_o     <= '0;
            ocr_o     <= '0;
            fcr_o     <= '0;
            ier_o     <= '0;
            hcr_o     <= '0;
            bus.rdata <= '0;
            bus.err   <= 1'b0;
        end else begin
            bus.err <= (wr_en && !addr_rw) || (rd_en && !addr_known);   // Single pulse
            if (rd_en) begin
                bus.rdata <= rd_word;   // Zero on unknown address
            end
            if (wr_en && bus.addr == uart_pkg::ADDR_TDR) begin
                tdr_o <= merge_bytes(tdr_o, bus.wdata, bus.strb);
            end
            if (wr_en && bus.addr == uart_pkg::ADDR_LCR) begin
                lcr_o <= merge_bytes(lcr_o, bus.wdata, bus.strb);
            end
            if (wr_en && bus.addr == uart_pkg::ADDR_OCR) begin
                ocr_o <= merge_bytes(ocr_o, bus.wdata, bus.strb);
            end
            if (ocr_o[uart_pkg::OCR_START]) begin
                ocr_o[uart_pkg::OCR_START] <= 1'b0;   // Start lasts one cycle
            end
            if (wr_en && bus.addr == uart_pkg::ADDR_FCR) begin
                fcr_o <= merge_bytes(fcr_o, bus.wdata, bus.strb);
            end
            if (wr_en && bus.addr == uart_pkg::ADDR_IER) begin
                ier_o <= merge_bytes(ier_o, bus.wdata, bus.strb);
            end
            if (wr_en && bus.addr == uart_pkg::ADDR_HCR) begin
                hcr_o <= merge_bytes(hcr_o, bus.wdata, bus.strb);
            end
        end
    end

endmodule

// File: hdl/uart_pkg.sv
package uart_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    parameter int DATA_W = 32;
    parameter int ADDR_W = 12;
    parameter int STRB_W = 4;

    typedef logic [DATA_W-1:0] reg_data_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    parameter logic [ADDR_W-1:0] ADDR_TDR = 12'h000;
    parameter logic [ADDR_W-1:0] ADDR_RDR = 12'h004;   // Read only
    parameter logic [ADDR_W-1:0] ADDR_LCR = 12'h008;
    parameter logic [ADDR_W-1:0] ADDR_OCR = 12'h00C;
    parameter logic [ADDR_W-1:0] ADDR_LSR = 12'h010;   // Read only
    parameter logic [ADDR_W-1:0] ADDR_FCR = 12'h014;
    parameter logic [ADDR_W-1:0] ADDR_IER = 12'h018;
    parameter logic [ADDR_W-1:0] ADDR_IIR = 12'h01C;   // Read only
    parameter logic [ADDR_W-1:0] ADDR_HCR = 12'h020;

    // Control and status bit positions
    parameter int OCR_START   = 1;   // Self-clearing
    parameter int FCR_RX_EN   = 0;
    parameter int HCR_LOOP    = 0;
    parameter int LSR_DR      = 0;
    parameter int LSR_OE      = 1;
    parameter int LSR_FE      = 2;
    parameter int LSR_TEMT    = 3;
    parameter int IER_RXDATA  = 0;
    parameter int IER_TXEMPTY = 1;
    parameter int IER_LINE    = 2;

    // Interrupt identification codes
    parameter logic [3:0] IIR_NONE    = 4'b0001;
    parameter logic [3:0] IIR_LINE    = 4'b0110;
    parameter logic [3:0] IIR_RXDATA  = 4'b0100;
    parameter logic [3:0] IIR_TXEMPTY = 4'b0010;

endpackage

// File: hdl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
    parameter int DIV_W = 16
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                rx_i,
    input  logic                loop_i,
    input  logic                loop_en_i,
    input  logic                enable_i,
    input  logic [DIV_W-1:0]    divisor_i,
    output uart_pkg::reg_data_t rdr_o,
    output logic                done_o,
    output logic                ferr_o
);

    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_HOLD} rx_state_t;

    rx_state_t        state;
    logic [2:0]       sync_q;   // Two sync stages plus edge history
    logic             line;
    logic             fall;
    logic [DIV_W-1:0] half;
    logic [DIV_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic [7:0]       rx_byte;
    logic             stop_ok;

    assign line  = sync_q[1];
    assign fall  = sync_q[2] && !sync_q[1];
    assign half  = divisor_i >> 1;
    assign rdr_o = {{(uart_pkg::DATA_W-8){1'b0}}, rx_byte};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q <= 3'b111;   // Line idles high
        end else begin
            sync_q <= {sync_q[1:0], loop_en_i ? loop_i : rx_i};
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == divisor_i) begin
            shift_q <= {line, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            stop_ok <= 1'b0;
            rx_byte <= '0;
            done_o  <= 1'b0;
            ferr_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            ferr_o <= 1'b0;
            cnt    <= cnt + 1'b1;
            if (!enable_i) begin
                state <= RX_IDLE;
            end else begin
                case (state)
                    RX_IDLE: begin
                        cnt <= '0;
                        if (fall) state <= RX_START;
                    end
                    RX_START: if (cnt == half) begin   // Mid start bit
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= line ? RX_IDLE : RX_DATA;
                    end
                    RX_DATA: if (cnt == divisor_i) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                    RX_STOP: if (cnt == divisor_i) begin
                        cnt     <= '0;
                        stop_ok <= line;
                        state   <= RX_HOLD;
                    end
                    RX_HOLD: if (cnt == half) begin   // Out to end of stop bit
                        state <= RX_IDLE;
                        if (stop_ok) begin
                            rx_byte <= shift_q;
                            done_o  <= 1'b1;
                        end else begin
                            ferr_o <= 1'b1;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

endmodule

// File: hdl/uart_top.sv
`timescale 1ns/10ps

module uart_top #(
    parameter int DIV_W = 16
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        en_i,
    input  logic                        wr_rd_i,
    input  logic [uart_pkg::ADDR_W-1:0] addr_i,
    input  uart_pkg::reg_data_t         pwdata_i,
    input  logic [uart_pkg::STRB_W-1:0] byte_strobe_i,
    output uart_pkg::reg_data_t         prdata_o,
    output logic                        addr_err_o,
    input  logic                        rx_i,
    output logic                        tx_o,
    output logic                        irq_o
);

    uart_pkg::reg_data_t tdr, rdr, lcr, ocr, lsr, fcr, ier, iir, hcr;
    logic                tx_line;
    logic                tx_idle;
    logic                rx_done;
    logic                rx_ferr;

    reg_bus_if bus ();

    assign bus.en     = en_i;
    assign bus.wr_rd  = wr_rd_i;
    assign bus.addr   = addr_i;
    assign bus.wdata  = pwdata_i;
    assign bus.strb   = byte_strobe_i;
    assign prdata_o   = bus.rdata;
    assign addr_err_o = bus.err;
    assign tx_o       = tx_line;   // Also the loopback source

    register_file u_regs (
        .clk, .reset_n, .bus(bus.target),
        .rdr_i(rdr), .lsr_i(lsr), .iir_i(iir),
        .tdr_o(tdr), .lcr_o(lcr), .ocr_o(ocr),
        .fcr_o(fcr), .ier_o(ier), .hcr_o(hcr)
    );

    uart_tx #(.DIV_W(DIV_W)) u_tx (
        .clk, .reset_n,
        .start_i(ocr[uart_pkg::OCR_START]), .data_i(tdr[7:0]),
        .divisor_i(lcr[DIV_W-1:0]), .tx_o(tx_line), .idle_o(tx_idle)
    );

    uart_rx #(.DIV_W(DIV_W)) u_rx (
        .clk, .reset_n,
        .rx_i, .loop_i(tx_line), .loop_en_i(hcr[uart_pkg::HCR_LOOP]),
        .enable_i(fcr[uart_pkg::FCR_RX_EN]), .divisor_i(lcr[DIV_W-1:0]),
        .rdr_o(rdr), .done_o(rx_done), .ferr_o(rx_ferr)
    );

    line_status u_status (
        .clk, .reset_n, .bus(bus.monitor),
        .rx_done_i(rx_done), .rx_ferr_i(rx_ferr), .tx_idle_i(tx_idle),
        .ier_i(ier), .lsr_o(lsr), .iir_o(iir), .irq_o
    );

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int DIV_W = 16
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             start_i,
    input  logic [7:0]       data_i,
    input  logic [DIV_W-1:0] divisor_i,
    output logic             tx_o,
    output logic             idle_o
);

    logic             busy;
    logic [DIV_W-1:0] bit_cnt;
    logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [7:0]       shift_q;
    logic [DIV_W-1:0] div_q;
    logic             launch;
    logic             bit_end;

    assign launch  = start_i && !busy;   // Ignored mid-frame
    assign bit_end = busy && (bit_cnt == div_q);
    assign idle_o  = !busy;

    // Frame byte and divisor held for the whole frame
    always_ff @(posedge clk) begin
        if (launch) begin
            shift_q <= data_i;
            div_q   <= divisor_i;
        end else if (bit_end && bit_idx < 4'd8) begin
            shift_q <= shift_q >> 1;   // LSB first
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else if (launch) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_o    <= 1'b0;   // Start bit
        end else if (bit_end) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;   // Stop bit done
            end else if (bit_idx == 4'd8) begin
                tx_o <= 1'b1;
            end else begin
                tx_o <= shift_q[0];
            end
        end else if (busy) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

endmodule

// File: verilog.f
hdl/uart_pkg.sv
hdl/reg_bus_if.sv
hdl/register_file.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/line_status.sv
hdl/uart_top.sv
dv/uart_checker.sv
dv/uart_tb.sv
